// File: common/mcl_consts.svh
`ifndef MCL_CONSTS_SVH
`define MCL_CONSTS_SVH

// Field widths
`define MCL_MEM_FIELD_W 4
`define MCL_MAGIC_W 9
`define MCL_DRAMA_W 3
`define MCL_REQ_W 4
`define MCL_CTX_W 3
`define MCL_SECTION_W 6
`define MCL_HELD_W 12
`define MCL_DIAG_W 6

// Highest section a long address may name
`define MCL_MAX_SECTION 31
`define MCL_DIAG_WORDS 8

`endif

// File: common/mcl_pkg.sv
package mcl_pkg;

`include "mcl_consts.svh"

  // Microword memory field, group select in the top bit
  typedef logic [`MCL_MEM_FIELD_W-1:0] memField_t;

  typedef enum logic [`MCL_MEM_FIELD_W-1:0] {
    // Group A
    memNop         = 4'd0,
    memArlInd      = 4'd1,
    memMbWait      = 4'd2,
    memRestoreVma  = 4'd3,
    memARead       = 4'd4,
    memBWrite      = 4'd5,
    memCondFetch   = 4'd6,
    memRegFunc     = 4'd7,
    // Group B
    memAdFunc      = 4'd8,
    memEaCalc      = 4'd9,
    memLoadAr      = 4'd10,
    memLoadArx     = 4'd11,
    memRwCycle     = 4'd12,
    memRpwCycle    = 4'd13,
    memWrite       = 4'd14,
    memUncondFetch = 4'd15
  } memFunc_e;

  typedef logic [`MCL_MAGIC_W-1:0] magic_t;

  // Operand fetch mode from the dispatch ROM
  typedef logic [`MCL_DRAMA_W-1:0] dramA_t;

  // Load AR, load ARX, pause, write (MSB first)
  typedef logic [`MCL_REQ_W-1:0] reqFlags_t;

  // User, public, extended (MSB first)
  typedef logic [`MCL_CTX_W-1:0] context_t;

  typedef logic [`MCL_SECTION_W-1:0] section_t;

  typedef logic [`MCL_HELD_W-1:0] heldWord_t;

  typedef logic [`MCL_DIAG_W-1:0] diagWord_t;

endpackage

// File: common/memFuncIf.sv
`timescale 1ns/1ps

interface memFuncIf;

  // Decoded function strobes
  logic adFunc;
  logic eaCalc;
  logic aRead;
  logic condFetch;

  // Unregistered fetch condition
  logic fetchEn;

  // Conditional fetch whose test failed
  logic condJumpFail;

  modport decoder (
    output adFunc, eaCalc, aRead, condFetch,
    output fetchEn, condJumpFail
  );

  modport ctx (
    input adFunc, eaCalc, condJumpFail
  );

endinterface

// File: src/memFuncDecode.sv
`timescale 1ns/1ps

module memFuncDecode (
  input  logic               clk,
  input  logic               arstN,
  input  mcl_pkg::memField_t memField,
  input  mcl_pkg::magic_t    magic,
  input  mcl_pkg::dramA_t    dramA,
  input  logic               dramB,
  input  logic               testSatisfied,
  input  logic [4:1]         adBits,
  memFuncIf.decoder          fn,
  output mcl_pkg::reqFlags_t reqFlags,
  output logic               vmaFetch,
  output logic               storeAr,
  output logic               reqEn,
  output logic               mboxCycReq
);

  import mcl_pkg::*;

  memFunc_e  func;
  reqFlags_t adGated;
  reqFlags_t reqNext;
  logic      isBWrite;
  logic      isLoadAr;
  logic      isLoadArx;
  logic      isRwCycle;
  logic      isRpwCycle;
  logic      isWrite;
  logic      isUncondFetch;

  assign func = memFunc_e'(memField);

  // One-hot decode of both groups, nop decodes nothing
  assign fn.adFunc      = (func == memAdFunc);
  assign fn.eaCalc      = (func == memEaCalc);
  assign fn.aRead       = (func == memARead);
  assign fn.condFetch   = (func == memCondFetch);
  assign isBWrite      = (func == memBWrite);
  assign isLoadAr      = (func == memLoadAr);
  assign isLoadArx     = (func == memLoadArx);
  assign isRwCycle     = (func == memRwCycle);
  assign isRpwCycle    = (func == memRpwCycle);
  assign isWrite       = (func == memWrite);
  assign isUncondFetch = (func == memUncondFetch);

  assign fn.fetchEn = isUncondFetch |
                      (fn.condFetch & magic[5] & testSatisfied) |
                      (fn.aRead & (dramA == 3'd1));

  assign fn.condJumpFail = fn.condFetch & magic[5] & ~testSatisfied;

  // Group B always, group A from code 4 up; B write waits on dramB
  assign reqEn = memField[3] | (memField[2] & (~isBWrite | dramB));

  // AD1 to AD4 map onto load AR .. write
  assign adGated = {4{fn.adFunc}} & {adBits[1], adBits[2], adBits[3], adBits[4]};

  always_comb begin
    reqNext[3] = isLoadAr | isRwCycle | isRpwCycle |
                 (fn.aRead & dramA[2]) |
                 (fn.eaCalc & magic[0]);
    reqNext[2] = isLoadArx | fn.fetchEn |
                 (fn.eaCalc & magic[1]);
    reqNext[1] = isRpwCycle |
                 (fn.aRead & (dramA == 3'd7));
    reqNext[0] = isWrite | isRwCycle | isRpwCycle | isBWrite |
                 (fn.aRead & ((dramA == 3'd3) | (dramA == 3'd6) | (dramA == 3'd7)));
    reqNext    = reqNext | adGated;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      reqFlags <= '0;
      vmaFetch <= 1'b0;
    end else if (reqEn) begin
      reqFlags <= reqNext;
      vmaFetch <= fn.fetchEn;
    end
  end

  // Pause and write with neither load
  assign storeAr = reqFlags[1] & reqFlags[0] & ~reqFlags[3] & ~reqFlags[2];

  assign mboxCycReq = memField[3] |
                      (fn.aRead & (dramA != 3'd0) & (dramA != 3'd2)) |
                      fn.condFetch;

endmodule

// File: src/vmaContext.sv
`timescale 1ns/1ps
`include "mcl_consts.svh"

module vmaContext (
  input  logic                clk,
  input  logic                arstN,
  memFuncIf.ctx               fn,
  input  logic [1:0]          vmaField,
  input  logic                userMode,
  input  logic                publicMode,
  input  logic                longMode,
  // AD5, AD6, AD8
  input  logic [2:0]          adBits,
  input  mcl_pkg::section_t   section,
  input  mcl_pkg::reqFlags_t  reqFlags,
  input  logic                vmaFetch,
  input  logic                holdVma,
  input  logic                condSelVma,
  input  mcl_pkg::heldWord_t  pcFlags,
  output mcl_pkg::context_t   vmaCtx,
  output logic                addrErr,
  output logic                loadVma,
  output mcl_pkg::heldWord_t  heldOrPc
);

  import mcl_pkg::*;

  localparam int HeldW = $bits(reqFlags_t) + $bits(context_t) + 2;

  context_t         ctxNext;
  logic             sectionHigh;
  logic             addrErrNext;
  logic [HeldW-1:0] heldReg;

  // A failed conditional jump leaves the VMA alone
  assign loadVma = (|vmaField) & ~fn.condJumpFail;

  always_comb begin
    if (fn.adFunc) begin
      ctxNext = adBits;
    end else begin
      ctxNext = {userMode, publicMode, fn.eaCalc & longMode};
    end
  end

  assign sectionHigh = (section > section_t'(`MCL_MAX_SECTION));
  assign addrErrNext = ctxNext[0] & ~fn.adFunc & sectionHigh;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      vmaCtx  <= '0;
      addrErr <= 1'b0;
    end else if (loadVma) begin
      vmaCtx  <= ctxNext;
      addrErr <= addrErrNext;
    end
  end

  // Snapshot for the condition logic
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      heldReg <= '0;
    end else if (holdVma) begin
      heldReg <= {reqFlags, vmaCtx, vmaFetch, addrErr};
    end
  end

  // Low three bits of the held word are spare
  always_comb begin
    if (condSelVma) begin
      heldOrPc = {heldReg, {($bits(heldWord_t) - HeldW){1'b0}}};
    end else begin
      heldOrPc = pcFlags;
    end
  end

endmodule

// File: src/diagReadback.sv
`timescale 1ns/1ps
`include "mcl_consts.svh"

module diagReadback (
  input  logic                                diagRead,
  input  logic [$clog2(`MCL_DIAG_WORDS)-1:0]  diagSel,
  input  mcl_pkg::reqFlags_t                  reqFlags,
  input  mcl_pkg::context_t                   vmaCtx,
  input  logic                                addrErr,
  input  logic                                vmaFetch,
  input  logic                                storeAr,
  input  logic                                mboxCycReq,
  input  logic                                reqEn,
  input  mcl_pkg::heldWord_t                  heldOrPc,
  output mcl_pkg::diagWord_t                  ebusData
);

  import mcl_pkg::*;

  diagWord_t words [`MCL_DIAG_WORDS];

  always_comb begin
    words[0] = {reqFlags, vmaCtx[2:1]};
    words[1] = {vmaCtx[0], addrErr, vmaFetch, storeAr, mboxCycReq, reqEn};
    // Held or PC word, three bits at a time from the top
    words[2] = {3'b000, heldOrPc[11:9]};
    words[3] = {3'b000, heldOrPc[8:6]};
    words[4] = {3'b000, heldOrPc[5:3]};
    words[5] = {3'b000, heldOrPc[2:0]};
    words[6] = '0;
    words[7] = '0;
  end

  // Bus is released to zero outside a diagnostic read
  always_comb begin
    if (diagRead) begin
      ebusData = words[diagSel];
    end else begin
      ebusData = '0;
    end
  end

endmodule

// File: src/memCtl.sv
`timescale 1ns/1ps
`include "mcl_consts.svh"

module memCtl (
  input  logic                                clk,
  input  logic                                arstN,
  input  mcl_pkg::memField_t                  memField,
  input  mcl_pkg::magic_t                     magic,
  input  mcl_pkg::dramA_t                     dramA,
  input  logic                                dramB,
  input  logic                                testSatisfied,
  input  logic [8:0]                          adBits,
  input  logic [1:0]                          vmaField,
  input  logic                                userMode,
  input  logic                                publicMode,
  input  logic                                longMode,
  input  mcl_pkg::section_t                   section,
  input  logic                                holdVma,
  input  logic                                condSelVma,
  input  mcl_pkg::heldWord_t                  pcFlags,
  input  logic                                diagRead,
  input  logic [$clog2(`MCL_DIAG_WORDS)-1:0]  diagSel,
  output mcl_pkg::reqFlags_t                  reqFlags,
  output logic                                storeAr,
  output logic                                mboxCycReq,
  output logic                                vmaFetch,
  output mcl_pkg::context_t                   vmaCtx,
  output logic                                addrErr,
  output logic                                loadVma,
  output mcl_pkg::heldWord_t                  heldOrPc,
  output mcl_pkg::diagWord_t                  ebusData
);

  logic reqEn;

  memFuncIf fnIf ();

  memFuncDecode memFuncDecode_i (
    .clk           (clk),
    .arstN         (arstN),
    .memField      (memField),
    .magic         (magic),
    .dramA         (dramA),
    .dramB         (dramB),
    .testSatisfied (testSatisfied),
    .adBits        (adBits[4:1]),
    .fn            (fnIf.decoder),
    .reqFlags      (reqFlags),
    .vmaFetch      (vmaFetch),
    .storeAr       (storeAr),
    .reqEn         (reqEn),
    .mboxCycReq    (mboxCycReq)
  );

  vmaContext vmaContext_i (
    .clk        (clk),
    .arstN      (arstN),
    .fn         (fnIf.ctx),
    .vmaField   (vmaField),
    .userMode   (userMode),
    .publicMode (publicMode),
    .longMode   (longMode),
    .adBits     ({adBits[5], adBits[6], adBits[8]}),
    .section    (section),
    .reqFlags   (reqFlags),
    .vmaFetch   (vmaFetch),
    .holdVma    (holdVma),
    .condSelVma (condSelVma),
    .pcFlags    (pcFlags),
    .vmaCtx     (vmaCtx),
    .addrErr    (addrErr),
    .loadVma    (loadVma),
    .heldOrPc   (heldOrPc)
  );

  diagReadback diagReadback_i (
    .diagRead   (diagRead),
    .diagSel    (diagSel),
    .reqFlags   (reqFlags),
    .vmaCtx     (vmaCtx),
    .addrErr    (addrErr),
    .vmaFetch   (vmaFetch),
    .storeAr    (storeAr),
    .mboxCycReq (mboxCycReq),
    .reqEn      (reqEn),
    .heldOrPc   (heldOrPc),
    .ebusData   (ebusData)
  );

endmodule

// File: tests/memCtl_properties.sv
`timescale 1ns/1ps

module memCtl_properties (
  input logic       clk,
  input logic       arstN,
  input logic [3:0] reqFlags,
  input logic       reqEn,
  input logic       storeAr,
  input logic       diagRead,
  input logic [5:0] ebusData
);

  // Flags only move on an edge that had reqEn
  reqHold: assert property (@(posedge clk) disable iff (!arstN)
    !$past(reqEn) |-> $stable(reqFlags))
    else $error("reqFlags changed without reqEn");

  busIdle: assert property (@(posedge clk) disable iff (!arstN)
    !diagRead |-> (ebusData == 6'd0))
    else $error("ebusData driven outside a diagnostic read");

  storeNoLoad: assert property (@(posedge clk) disable iff (!arstN)
    $rose(storeAr) |-> !(reqFlags[3] | reqFlags[2]))
    else $error("storeAr rose with a load flag set");

endmodule

bind memCtl memCtl_properties memCtl_props_i (
  .clk      (clk),
  .arstN    (arstN),
  .reqFlags (reqFlags),
  .reqEn    (reqEn),
  .storeAr  (storeAr),
  .diagRead (diagRead),
  .ebusData (ebusData)
);

// File: tests/memCtlTb.sv
`timescale 1ns/1ps

module memCtlTb;

  import mcl_pkg::*;

  logic               clk;
  logic               arstN;
  memField_t          memField;
  magic_t             magic;
  dramA_t             dramA;
  logic               dramB;
  logic               testSatisfied;
  logic [8:0]         adBits;
  logic [1:0]         vmaField;
  logic               userMode;
  logic               publicMode;
  logic               longMode;
  section_t           section;
  logic               holdVma;
  logic               condSelVma;
  heldWord_t          pcFlags;
  logic               diagRead;
  logic [2:0]         diagSel;
  reqFlags_t          reqFlags;
  logic               storeAr;
  logic               mboxCycReq;
  logic               vmaFetch;
  context_t           vmaCtx;
  logic               addrErr;
  logic               loadVma;
  heldWord_t          heldOrPc;
  diagWord_t          ebusData;

  int unsigned lcgState;
  int          passCount;
  int          failCount;
  int          errCount;
  bit          testBad;
  int          fd;
  int          nRead;
  string       line;
  string       tName;
  // Columns 0 to 15 hold stimulus and 16 to 24 expected values
  logic [31:0] v [25];

  memCtl memCtl_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Global guard against a stuck run
  initial begin
    repeat (3000) @(posedge clk);
    $display("Timeout: the run did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return 32'(lcgState >> 16);
  endfunction

  task automatic checkEq(input string name, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s %s expected %0h actual %0h", name, what, exp, act);
      errCount++;
      testBad = 1'b1;
    end
  endtask

  task automatic finishTest(input string name);
    if (testBad) begin
      failCount++;
      $display("test %s done with errors", name);
    end else begin
      passCount++;
      $display("test %s done ok", name);
    end
    testBad = 1'b0;
  endtask

  task automatic runLine();
    logic [31:0] r;
    @(posedge clk);
    r = lcgNext();
    memField      <= v[0][3:0];
    magic         <= v[1][8:0];
    dramA         <= v[2][2:0];
    dramB         <= v[3][0];
    testSatisfied <= v[4][0];
    adBits        <= v[5][8:0];
    vmaField      <= v[6][1:0];
    userMode      <= v[7][0];
    publicMode    <= v[8][0];
    longMode      <= v[9][0];
    section       <= v[10][5:0];
    holdVma       <= v[11][0];
    condSelVma    <= v[12][0];
    // PC flags are a don't-care while the held word is selected
    pcFlags       <= (v[12][0]) ? r[11:0] : v[13][11:0];
    diagRead      <= v[14][0];
    diagSel       <= (v[14][0]) ? v[15][2:0] : r[14:12];
    @(negedge clk);
    checkEq(tName, "mboxCycReq", v[16], 32'(mboxCycReq));
    checkEq(tName, "loadVma", v[17], 32'(loadVma));
    // Strobes drop after one cycle while observation inputs stay
    @(posedge clk);
    memField <= '0;
    vmaField <= '0;
    holdVma  <= 1'b0;
    @(negedge clk);
    checkEq(tName, "reqFlags", v[18], 32'(reqFlags));
    checkEq(tName, "storeAr", v[19], 32'(storeAr));
    checkEq(tName, "vmaFetch", v[20], 32'(vmaFetch));
    checkEq(tName, "context", v[21], 32'(vmaCtx));
    checkEq(tName, "addrErr", v[22], 32'(addrErr));
    checkEq(tName, "heldOrPc", v[23], 32'(heldOrPc));
    checkEq(tName, "ebusData", v[24], 32'(ebusData));
  endtask

  initial begin
    lcgState = 36;
    passCount = 0;
    failCount = 0;
    errCount = 0;
    testBad = 1'b0;
    arstN = 1'b0;
    memField = '0;
    magic = '0;
    dramA = '0;
    dramB = 1'b0;
    testSatisfied = 1'b0;
    adBits = '0;
    vmaField = '0;
    userMode = 1'b0;
    publicMode = 1'b0;
    longMode = 1'b0;
    section = '0;
    holdVma = 1'b0;
    condSelVma = 1'b1;
    pcFlags = '0;
    diagRead = 1'b0;
    diagSel = '0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkEq("reset", "reqFlags", 0, 32'(reqFlags));
    checkEq("reset", "context", 0, 32'(vmaCtx));
    checkEq("reset", "vmaFetch", 0, 32'(vmaFetch));
    checkEq("reset", "addrErr", 0, 32'(addrErr));
    checkEq("reset", "heldOrPc", 0, 32'(heldOrPc));
    finishTest("reset");
    fd = $fopen("tests/memCtl_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/memCtl_testdata.txt");
      errCount++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        nRead = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          nRead = $sscanf(line,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            tName, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
            v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
            v[19], v[20], v[21], v[22], v[23], v[24]);
          if (nRead != 26) begin
            $display("Malformed data line: %s", line);
            errCount++;
          end else begin
            runLine();
            finishTest(tName);
          end
        end
      end
      $fclose(fd);
    end
    $display("Tests: %0d passed, %0d failed, %0d mismatches", passCount, failCount,
             errCount);
    if (errCount == 0 && failCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tests/memCtl_testdata.txt
# name mf mag da db ts ad vf um pm lm sec hv cs pc dr ds | mbox lv req sa vfch ctx ae hop eb
# all values hex; mbox and lv checked mid-cycle, the rest one cycle later
b_adfunc     8 000 0 0 0 014 0 0 0 0 00 0 0 000 0 0  1 0 5 0 0 0 0 000 00
b_adstore    8 000 0 0 0 018 0 0 0 0 00 0 0 000 0 0  1 0 3 1 0 0 0 000 00
b_eacalc     9 003 0 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 c 0 0 0 0 000 00
b_loadar     a 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 8 0 0 0 0 000 00
b_loadarx    b 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 4 0 0 0 0 000 00
b_rw         c 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 9 0 0 0 0 000 00
b_rpw        d 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 b 0 0 0 0 000 00
b_write      e 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 1 0 0 0 0 000 00
b_fetch      f 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 4 0 1 0 0 000 00
aread_d0     4 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  0 0 0 0 0 0 0 000 00
aread_d1     4 000 1 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 4 0 1 0 0 000 00
aread_d2     4 000 2 0 0 000 0 0 0 0 00 0 0 000 0 0  0 0 0 0 0 0 0 000 00
aread_d3     4 000 3 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 1 0 0 0 0 000 00
aread_d4     4 000 4 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 8 0 0 0 0 000 00
aread_d5     4 000 5 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 8 0 0 0 0 000 00
aread_d6     4 000 6 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 9 0 0 0 0 000 00
aread_d7     4 000 7 0 0 000 0 0 0 0 00 0 0 000 0 0  1 0 b 0 0 0 0 000 00
bwrite_nodb  5 000 0 0 0 000 0 0 0 0 00 0 0 000 0 0  0 0 b 0 0 0 0 000 00
bwrite_db    5 000 0 1 0 000 0 0 0 0 00 0 0 000 0 0  0 0 1 0 0 0 0 000 00
cfetch_pass  6 020 0 0 1 000 1 1 0 0 00 0 0 000 0 0  1 1 4 0 1 4 0 000 00
cfetch_fail  6 020 0 0 0 000 1 0 1 0 00 0 0 000 0 0  1 0 0 0 0 4 0 000 00
ctx_modes    0 000 0 0 0 000 2 1 1 1 00 0 0 000 0 0  0 1 0 0 0 6 0 000 00
ctx_ad       8 000 0 0 0 160 1 0 0 0 3f 0 0 000 0 0  1 1 0 0 0 7 0 000 00
ea_sec31     9 000 0 0 0 000 3 0 0 1 1f 0 0 000 0 0  1 1 0 0 0 1 0 000 00
ea_sec32     9 000 0 0 0 000 3 0 0 1 20 0 0 000 0 0  1 1 0 0 0 1 1 000 00
diag_err     0 000 0 0 0 000 0 0 0 0 00 0 0 000 1 1  0 0 0 0 0 1 1 000 30
ea_nolong    9 000 0 0 0 000 3 0 0 0 3f 0 0 000 0 0  1 1 0 0 0 0 0 000 00
hold_setup   d 000 0 0 0 000 3 1 1 0 00 0 0 000 0 0  1 1 b 0 0 6 0 000 00
hold_cap     0 000 0 0 0 000 0 0 0 0 00 1 0 abc 0 0  0 0 b 0 0 6 0 abc 00
hold_sel     0 000 0 0 0 000 0 0 0 0 00 0 1 000 0 0  0 0 b 0 0 6 0 bc0 00
hold_pc      0 000 0 0 0 000 0 0 0 0 00 0 0 5a5 0 0  0 0 b 0 0 6 0 5a5 00
hold_sel2    0 000 0 0 0 000 0 0 0 0 00 0 1 000 0 0  0 0 b 0 0 6 0 bc0 00
diag_0       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 0  0 0 b 0 0 6 0 bc0 2f
diag_1       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 1  0 0 b 0 0 6 0 bc0 00
diag_2       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 2  0 0 b 0 0 6 0 bc0 05
diag_3       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 3  0 0 b 0 0 6 0 bc0 07
diag_4       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 4  0 0 b 0 0 6 0 bc0 00
diag_5       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 5  0 0 b 0 0 6 0 bc0 00
diag_6       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 6  0 0 b 0 0 6 0 bc0 00
diag_7       0 000 0 0 0 000 0 0 0 0 00 0 1 000 1 7  0 0 b 0 0 6 0 bc0 00
diag_off     0 000 0 0 0 000 0 0 0 0 00 0 1 000 0 0  0 0 b 0 0 6 0 bc0 00

// File: sim.f
+incdir+common
common/mcl_pkg.sv
common/memFuncIf.sv
src/memFuncDecode.sv
src/vmaContext.sv
src/diagReadback.sv
src/memCtl.sv
tests/memCtl_properties.sv
tests/memCtlTb.sv

// File: run.sh
#!/bin/sh
# Build and run the memCtl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module memCtlTb -f sim.f -o memCtlSim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/memCtlSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
